//--- htif_bridge.f
design/htif_types_pkg.sv
design/htif_regmap_pkg.sv
design/host_queue_if.sv
design/word_fifo.sv
design/host_in_unpacker.sv
design/host_out_packer.sv
design/axi_reg_ctrl.sv
design/htif_bridge.sv
tests/htif_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the htif_bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module htif_bridge_tb \
  -f htif_bridge.f -o htif_bridge_sim > build.log 2>&1 \
  && ./obj_dir/htif_bridge_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST PASS" sim.log 2>/dev/null && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tests/htif_bridge_tb.sv
`default_nettype none

module htif_bridge_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH       = 32;
  localparam int N_IN        = 64;   // Words sent through host-in
  localparam int N_GROUPS    = 12;   // Host-out groups of four pairs
  localparam int WATCHDOG_NS = 20 * (40 * (N_IN + 8 * N_GROUPS + 2 * DEPTH) + 1000);

  logic userclk2 = 1'b0;
  logic reset;
  logic awvalid, wvalid, bready, arvalid, rready;
  logic awready, wready, bvalid, arready, rvalid, rlast;
  htif_types_pkg::bus_word_t  awaddr, wdata, araddr, rdata, rd_word;
  htif_types_pkg::axi_id_t    awid, arid, bid, rid;
  logic                       host_in_valid, host_in_ready, host_out_valid, host_out_ready;
  htif_types_pkg::host_half_t host_in_bits, host_out_bits, first_half;
  logic                       reset_cpu;

  logic [31:0] rng = 32'h9ac3_7dd6;
  logic [31:0] stall_rng = 32'h9ac3_7dd6 ^ 32'h5a5a_0f0f;  // Separate stream for stalls
  int          in_ready_mode = 0;  // 0 held low, 1 random, 2 held high
  int          exp_count = 0;
  int          i, g, k, guard;
  logic        in_hi = 1'b0;
  logic        have_first = 1'b0;
  htif_types_pkg::bus_word_t in_ref[$];
  htif_types_pkg::bus_word_t out_ref[$];
  htif_types_pkg::host_half_t exp_half;

  htif_bridge #(.DEPTH(DEPTH)) dut0 (.*);

  always #10 userclk2 = !userclk2;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic mismatch(input string msg);
    abort_run($sformatf("Mismatch at %0t ns: %s", $time, msg));
  endtask

  // ------------------------------------------------------------
  // Bus access tasks start on a falling edge
  // ------------------------------------------------------------
  task automatic bus_write(input htif_types_pkg::reg_addr_t wa,
                           input htif_types_pkg::bus_word_t data,
                           input htif_types_pkg::axi_id_t id, input int hold);
    int n;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = htif_types_pkg::bus_word_t'({wa, 2'b00});
    wdata   = data;
    awid    = id;
    bready  = 1'b1;
    @(negedge userclk2);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    for (n = 0; n < hold; n++)
    begin
      assert (!awready) else mismatch("awready high while host-in is full");
      @(negedge userclk2);
    end
    if (hold > 0)
      in_ready_mode = 2;  // Let the chip drain one word
    n = 0;
    while (!awready)
    begin
      @(negedge userclk2);
      n++;
      if (n > 200)
        abort_run("Write never completed, awready stayed low");
    end
    assert (wready) else mismatch("wready low while awready high");
    assert (reset_cpu == (wa == 5'd31)) else mismatch("reset_cpu wrong on write completion");
    if (wa == 5'd0)
      in_ref.push_back(data);
    @(negedge userclk2);
    assert (bvalid && bid == id) else mismatch("bvalid or bid wrong after write");
    assert (!reset_cpu) else mismatch("reset_cpu longer than one cycle");
    @(negedge userclk2);
    assert (!bvalid) else mismatch("bvalid held after bready");
  endtask

  task automatic bus_read(input htif_types_pkg::reg_addr_t ra,
                          input htif_types_pkg::axi_id_t id,
                          output htif_types_pkg::bus_word_t data);
    int stall;
    arvalid = 1'b1;
    araddr  = htif_types_pkg::bus_word_t'({ra, 2'b00});
    arid    = id;
    rready  = 1'b0;
    @(negedge userclk2);
    arvalid = 1'b0;
    rng     = xorshift32(rng);
    stall   = int'(rng % 3);
    repeat (stall)
    begin
      assert (rvalid && !arready) else mismatch("rvalid dropped during rready stall");
      @(negedge userclk2);
    end
    rready = 1'b1;
    assert (rvalid && rlast && rid == id) else mismatch("read response or rid wrong");
    data = rdata;
    @(negedge userclk2);
    rready = 1'b0;
    assert (!rvalid && arready) else mismatch("read did not return to idle");
  endtask

  task automatic check_count(input int expected);
    bus_read(5'd0, 12'h0c1, rd_word);
    assert (rd_word == expected) else mismatch($sformatf("count %0d, expected %0d",
                                                         rd_word, expected));
  endtask

  task automatic send_half(input htif_types_pkg::host_half_t h);
    host_out_valid = 1'b1;
    host_out_bits  = h;
    while (!host_out_ready)
      @(negedge userclk2);
    @(negedge userclk2);
    host_out_valid = 1'b0;
    if (have_first)
    begin
      out_ref.push_back({h, first_half});  // Second half goes high
      exp_count++;
    end
    first_half = h;
    have_first = !have_first;
  endtask

  // Chip side ready driver
  always @(negedge userclk2)
  begin
    stall_rng <= xorshift32(stall_rng);
    host_in_ready <= (in_ready_mode == 2) || (in_ready_mode == 1 && stall_rng[7]);
  end

  // Host-in monitor against the reference queue
  always @(posedge userclk2)
  begin
    if (!reset && host_in_valid && host_in_ready)
    begin
      assert (in_ref.size() != 0) else mismatch("host-in transfer with nothing queued");
      exp_half = in_hi ? in_ref[0][31:16] : in_ref[0][15:0];
      assert (host_in_bits == exp_half) else mismatch("host_in_bits out of order");
      if (in_hi)
        void'(in_ref.pop_front());
      in_hi = !in_hi;
    end
  end

  a_rlast: assert property (@(posedge userclk2) disable iff (reset) rvalid |-> rlast)
    else mismatch("rlast low during read response");
  a_cpu_pulse: assert property (@(posedge userclk2) disable iff (reset)
    reset_cpu |=> !reset_cpu) else mismatch("reset_cpu wider than one cycle");

  initial
  begin
    #(WATCHDOG_NS);
    abort_run("Timeout, the watchdog expired before the tests finished");
  end

  initial
  begin
    reset = 1'b1;
    {awvalid, wvalid, bready, arvalid, rready, host_out_valid} = '0;
    {awaddr, wdata, araddr} = '0;
    {awid, arid, host_out_bits, first_half} = '0;
    host_in_ready = 1'b0;
    repeat (2) @(posedge userclk2);
    @(negedge userclk2);
    reset = 1'b0;

    // Reset state
    assert (!rvalid && !rlast && !bvalid && !awready && !wready && !reset_cpu)
      else mismatch("control output not idle after reset");
    assert (arready && !host_in_valid && host_out_ready) else mismatch("bad idle after reset");
    check_count(0);

    // Host-in order under random stalls
    in_ready_mode = 1;
    for (i = 0; i < N_IN; i++)
    begin
      rng = xorshift32(rng);
      bus_write(5'd0, rng, htif_types_pkg::axi_id_t'(i), 0);
    end
    in_ready_mode = 2;
    guard = 0;
    while (in_ref.size() != 0 && guard < 1000)
    begin
      @(negedge userclk2);
      guard++;
    end
    assert (in_ref.size() == 0) else abort_run("Host-in queue did not drain");

    // Host-out packing
    for (g = 0; g < N_GROUPS; g++)
    begin
      for (k = 0; k < 8; k++)
      begin
        rng = xorshift32(rng);
        send_half(rng[15:0]);
      end
      check_count(exp_count);
      for (k = 0; k < 3; k++)
      begin
        bus_read(5'd1, htif_types_pkg::axi_id_t'(g * 4 + k), rd_word);
        assert (rd_word == out_ref[0]) else mismatch("host-out word wrong");
        void'(out_ref.pop_front());
        exp_count--;
        check_count(exp_count);
      end
    end
    while (out_ref.size() != 0)
    begin
      bus_read(5'd1, 12'h7a2, rd_word);
      assert (rd_word == out_ref[0]) else mismatch("host-out word wrong in drain");
      void'(out_ref.pop_front());
      exp_count--;
    end
    check_count(0);

    // Back-pressure on a full host-in queue
    in_ready_mode = 0;
    repeat (2) @(negedge userclk2);
    for (i = 0; i < DEPTH; i++)
      bus_write(5'd0, {i[15:0], ~i[15:0]}, 12'h300, 0);
    bus_write(5'd0, 32'hfeed_0bad, 12'h301, 6);
    guard = 0;
    while (in_ref.size() != 0 && guard < 2000)
    begin
      @(negedge userclk2);
      guard++;
    end
    assert (in_ref.size() == 0) else abort_run("Host-in queue did not drain after stall");

    // Chip reset pulse, IDs and undefined reads
    rng = xorshift32(rng);
    bus_write(5'd31, 32'h0, rng[11:0], 0);
    assert (!host_in_valid) else mismatch("chip reset write changed host-in");
    check_count(0);
    rng = xorshift32(rng);
    bus_read(5'd5, rng[23:12], rd_word);
    assert (rd_word == 32'h0) else mismatch("undefined address read not zero");

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/htif_bridge.sv
`default_nettype none

module htif_bridge #(
  parameter int DEPTH = 32  // Queue entries as a power of two
) (
  input  wire                             userclk2,
  input  wire                             reset,
  // Processor bus
  input  wire                             awvalid,
  input  wire htif_types_pkg::bus_word_t  awaddr,
  input  wire htif_types_pkg::axi_id_t    awid,
  output logic                            awready,
  input  wire                             wvalid,
  input  wire htif_types_pkg::bus_word_t  wdata,
  output logic                            wready,
  output logic                            bvalid,
  output htif_types_pkg::axi_id_t         bid,
  input  wire                             bready,
  input  wire                             arvalid,
  input  wire htif_types_pkg::bus_word_t  araddr,
  input  wire htif_types_pkg::axi_id_t    arid,
  output logic                            arready,
  output logic                            rvalid,
  output logic                            rlast,
  output htif_types_pkg::bus_word_t       rdata,
  output htif_types_pkg::axi_id_t         rid,
  input  wire                             rready,
  // Chip host port
  output logic                            host_in_valid,
  input  wire                             host_in_ready,
  output htif_types_pkg::host_half_t      host_in_bits,
  input  wire                             host_out_valid,
  output logic                            host_out_ready,
  input  wire htif_types_pkg::host_half_t host_out_bits,
  output logic                            reset_cpu
);

  host_queue_if #(.DEPTH(DEPTH)) q_if ();

  axi_reg_ctrl #(
    .DEPTH (DEPTH)
  ) ctrl0 (
    .userclk2 (userclk2),
    .reset    (reset),
    .q        (q_if.ctrl),
    .awvalid  (awvalid),
    .awaddr   (awaddr),
    .awid     (awid),
    .awready  (awready),
    .wvalid   (wvalid),
    .wdata    (wdata),
    .wready   (wready),
    .bvalid   (bvalid),
    .bid      (bid),
    .bready   (bready),
    .arvalid  (arvalid),
    .araddr   (araddr),
    .arid     (arid),
    .arready  (arready),
    .rvalid   (rvalid),
    .rlast    (rlast),
    .rdata    (rdata),
    .rid      (rid),
    .rready   (rready),
    .reset_cpu(reset_cpu)
  );

  // Processor to chip
  host_in_unpacker #(
    .DEPTH (DEPTH)
  ) unpack0 (
    .userclk2      (userclk2),
    .reset         (reset),
    .q             (q_if.host_in),
    .host_in_valid (host_in_valid),
    .host_in_ready (host_in_ready),
    .host_in_bits  (host_in_bits)
  );

  // Chip to processor
  host_out_packer #(
    .DEPTH (DEPTH)
  ) pack0 (
    .userclk2       (userclk2),
    .reset          (reset),
    .q              (q_if.host_out),
    .host_out_valid (host_out_valid),
    .host_out_ready (host_out_ready),
    .host_out_bits  (host_out_bits)
  );

endmodule

`default_nettype wire

//--- design/axi_reg_ctrl.sv
`default_nettype none

module axi_reg_ctrl #(
  parameter int DEPTH = 32
) (
  input  wire                            userclk2,
  input  wire                            reset,
  host_queue_if.ctrl                     q,
  // Write address
  input  wire                            awvalid,
  input  wire htif_types_pkg::bus_word_t awaddr,
  input  wire htif_types_pkg::axi_id_t   awid,
  output logic                           awready,
  // Write data
  input  wire                            wvalid,
  input  wire htif_types_pkg::bus_word_t wdata,
  output logic                           wready,
  // Write response
  output logic                           bvalid,
  output htif_types_pkg::axi_id_t        bid,
  input  wire                            bready,
  // Read address
  input  wire                            arvalid,
  input  wire htif_types_pkg::bus_word_t araddr,
  input  wire htif_types_pkg::axi_id_t   arid,
  output logic                           arready,
  // Read data
  output logic                           rvalid,
  output logic                           rlast,
  output htif_types_pkg::bus_word_t      rdata,
  output htif_types_pkg::axi_id_t        rid,
  input  wire                            rready,
  output logic                           reset_cpu
);

  localparam int CNT_W = $clog2(DEPTH) + 1;
  localparam int A_LSB = htif_regmap_pkg::REG_ADDR_LSB;
  localparam int A_W   = htif_types_pkg::REG_ADDR_W;

  htif_regmap_pkg::rd_state_e rd_state;
  htif_regmap_pkg::wr_state_e wr_state;
  htif_types_pkg::reg_addr_t  raddr_q;
  htif_types_pkg::reg_addr_t  waddr_q;
  htif_types_pkg::axi_id_t    arid_q;
  htif_types_pkg::axi_id_t    awid_q;
  htif_types_pkg::bus_word_t  wdata_q;
  logic                       rd_accept;
  logic                       wr_accept;
  logic                       is_data_wr;
  logic                       wr_done;

  // ----------------------------------------------------------
  // Read channel
  // ----------------------------------------------------------
  assign arready   = (rd_state == htif_regmap_pkg::RD_IDLE);
  assign rvalid    = (rd_state == htif_regmap_pkg::RD_RESP);
  assign rlast     = rvalid;  // Single beat
  assign rid       = arid_q;
  assign rd_accept = arready && arvalid;

  always_ff @(posedge userclk2)
  begin
    if (reset)
      rd_state <= htif_regmap_pkg::RD_IDLE;
    else
    begin
      case (rd_state)
        htif_regmap_pkg::RD_IDLE:
          if (arvalid)
            rd_state <= htif_regmap_pkg::RD_RESP;
        htif_regmap_pkg::RD_RESP:
          if (rready)
            rd_state <= htif_regmap_pkg::RD_IDLE;
        default:
          rd_state <= htif_regmap_pkg::RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge userclk2)
  begin
    if (rd_accept)
    begin
      raddr_q <= araddr[A_LSB +: A_W];
      arid_q  <= arid;
    end
  end

  always_comb
  begin
    rdata = '0;
    if (rvalid)
    begin
      case (raddr_q)
        htif_regmap_pkg::RD_COUNT_ADDR:
          rdata = {{(htif_types_pkg::BUS_W - CNT_W){1'b0}}, q.out_count};
        htif_regmap_pkg::RD_DATA_ADDR:
          rdata = q.out_head;
        default:
          rdata = '0;  // Undefined addresses read as zero
      endcase
    end
  end

  // Pop once the head word has been taken, never on an empty queue
  assign q.out_rden = rvalid && rready && (raddr_q == htif_regmap_pkg::RD_DATA_ADDR)
                      && (q.out_count != '0);

  // ----------------------------------------------------------
  // Write channel
  // ----------------------------------------------------------
  assign wr_accept  = (wr_state == htif_regmap_pkg::WR_IDLE) && awvalid && wvalid;
  assign is_data_wr = (waddr_q == htif_regmap_pkg::WR_DATA_ADDR);
  assign wr_done    = (wr_state == htif_regmap_pkg::WR_COMMIT) && !(is_data_wr && q.in_full);

  assign awready   = wr_done;
  assign wready    = wr_done;
  assign bvalid    = (wr_state == htif_regmap_pkg::WR_ACK);
  assign bid       = awid_q;
  assign q.in_wren = wr_done && is_data_wr;
  assign q.in_data = wdata_q;
  assign reset_cpu = wr_done && (waddr_q == htif_regmap_pkg::WR_RESET_ADDR);

  always_ff @(posedge userclk2)
  begin
    if (reset)
      wr_state <= htif_regmap_pkg::WR_IDLE;
    else
    begin
      case (wr_state)
        htif_regmap_pkg::WR_IDLE:
          if (awvalid && wvalid)
            wr_state <= htif_regmap_pkg::WR_COMMIT;
        htif_regmap_pkg::WR_COMMIT:
          if (wr_done)
            wr_state <= htif_regmap_pkg::WR_ACK;  // Held here while host-in is full
        htif_regmap_pkg::WR_ACK:
          if (bready)
            wr_state <= htif_regmap_pkg::WR_IDLE;
        default:
          wr_state <= htif_regmap_pkg::WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge userclk2)
  begin
    if (wr_accept)
    begin
      waddr_q <= awaddr[A_LSB +: A_W];
      awid_q  <= awid;
      wdata_q <= wdata;
    end
  end

  // A stalled response keeps its beat and ID, with no new address taken
  a_rd_hold: assert property (@(posedge userclk2) disable iff (reset)
    rvalid && !rready |=> rvalid && !arready && $stable(rid));

  a_reset_pulse: assert property (@(posedge userclk2) disable iff (reset)
    reset_cpu |=> !reset_cpu);

endmodule

`default_nettype wire

//--- design/host_out_packer.sv
`default_nettype none

module host_out_packer #(
  parameter int DEPTH = 32
) (
  input  wire                             userclk2,
  input  wire                             reset,
  host_queue_if.host_out                  q,
  input  wire                             host_out_valid,
  output logic                            host_out_ready,
  input  wire htif_types_pkg::host_half_t host_out_bits
);

  htif_types_pkg::host_half_t first_half;  // Low half of the word in progress
  logic                       pair_sel;    // First half already held
  logic                       full;
  logic                       accept;

  word_fifo #(
    .DEPTH (DEPTH)
  ) out_fifo (
    .userclk2 (userclk2),
    .reset    (reset),
    .wren     (accept && pair_sel),
    .rden     (q.out_rden),
    .din      ({host_out_bits, first_half}),
    .dout     (q.out_head),
    .full     (full),
    .empty    (),
    .count    (q.out_count)
  );

  assign host_out_ready = !full;
  assign accept         = host_out_valid && host_out_ready;

  // ----------------------------------------------------------
  // Half pairing
  // ----------------------------------------------------------
  always_ff @(posedge userclk2)
  begin
    if (reset)
      pair_sel <= 1'b0;
    else if (accept)
      pair_sel <= !pair_sel;
  end

  always_ff @(posedge userclk2)
  begin
    if (accept && !pair_sel)
      first_half <= host_out_bits;
  end

endmodule

`default_nettype wire

//--- design/host_in_unpacker.sv
`default_nettype none

module host_in_unpacker #(
  parameter int DEPTH = 32
) (
  input  wire                        userclk2,
  input  wire                        reset,
  host_queue_if.host_in              q,
  output logic                       host_in_valid,
  input  wire                        host_in_ready,
  output htif_types_pkg::host_half_t host_in_bits
);

  localparam int HW = htif_types_pkg::HALF_W;

  htif_types_pkg::bus_word_t head;
  logic                      empty;
  logic                      half_sel;  // Set while the high half is shown
  logic                      xfer;

  word_fifo #(
    .DEPTH (DEPTH)
  ) in_fifo (
    .userclk2 (userclk2),
    .reset    (reset),
    .wren     (q.in_wren),
    .rden     (xfer && half_sel),  // Pop on the second half
    .din      (q.in_data),
    .dout     (head),
    .full     (q.in_full),
    .empty    (empty),
    .count    ()
  );

  assign host_in_valid = !empty;
  assign xfer          = host_in_valid && host_in_ready;
  assign host_in_bits  = half_sel ? head[HW +: HW] : head[0 +: HW];

  always_ff @(posedge userclk2)
  begin
    if (reset)
      half_sel <= 1'b0;
    else if (xfer)
      half_sel <= !half_sel;
  end

endmodule

`default_nettype wire

//--- design/word_fifo.sv
`default_nettype none

module word_fifo #(
  parameter  int DEPTH = 32,
  localparam int CNT_W = $clog2(DEPTH) + 1
) (
  input  wire                            userclk2,
  input  wire                            reset,
  input  wire                            wren,
  input  wire                            rden,
  input  wire htif_types_pkg::bus_word_t din,
  output htif_types_pkg::bus_word_t      dout,
  output logic                           full,
  output logic                           empty,
  output logic [CNT_W-1:0]               count
);

  localparam int PTR_W = $clog2(DEPTH);

  htif_types_pkg::bus_word_t mem [DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [CNT_W-1:0]          cnt_next;
  logic                      do_write;
  logic                      do_read;

  assign do_read  = rden && !empty;
  assign do_write = wren && (!full || do_read);  // A pop frees the slot

  always_comb
  begin
    cnt_next = count;
    if (do_write && !do_read)
      cnt_next = count + 1'b1;
    else if (do_read && !do_write)
      cnt_next = count - 1'b1;
  end

  // Pointers and flags
  always_ff @(posedge userclk2)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end
    else
    begin
      if (do_write)
        wr_ptr <= wr_ptr + 1'b1;  // Wraps since DEPTH is a power of two
      if (do_read)
        rd_ptr <= rd_ptr + 1'b1;
      count <= cnt_next;
      full  <= (cnt_next == CNT_W'(DEPTH));
      empty <= (cnt_next == '0);
    end
  end

  always_ff @(posedge userclk2)
  begin
    if (do_write)
      mem[wr_ptr] <= din;
  end

  assign dout = mem[rd_ptr];  // First word falls through

  a_no_lost_write: assert property (@(posedge userclk2) disable iff (reset)
    wren && full |-> rden);

  a_count_bound: assert property (@(posedge userclk2) disable iff (reset)
    count <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- design/host_queue_if.sv
`default_nettype none

interface host_queue_if #(
  parameter int DEPTH = 32
) ();

  localparam int CNT_W = $clog2(DEPTH) + 1;

  // Host-in side
  logic                      in_wren;   // One-cycle push strobe
  htif_types_pkg::bus_word_t in_data;
  logic                      in_full;

  // Host-out side
  logic                      out_rden;  // One-cycle pop strobe
  htif_types_pkg::bus_word_t out_head;
  logic [CNT_W-1:0]          out_count;

  modport ctrl (output in_wren, in_data, out_rden,
                input  in_full, out_head, out_count);

  modport host_in (input in_wren, in_data, output in_full);

  modport host_out (input out_rden, output out_head, out_count);

endinterface

`default_nettype wire

//--- design/htif_regmap_pkg.sv
`default_nettype none

package htif_regmap_pkg;

  // Word address sits at byte address bits 6:2
  localparam int REG_ADDR_LSB = 2;

  // Read side
  localparam htif_types_pkg::reg_addr_t RD_COUNT_ADDR = 5'd0;  // Host-out fill count
  localparam htif_types_pkg::reg_addr_t RD_DATA_ADDR  = 5'd1;  // Host-out head with pop

  // Write side
  localparam htif_types_pkg::reg_addr_t WR_DATA_ADDR  = 5'd0;  // Push into host-in
  localparam htif_types_pkg::reg_addr_t WR_RESET_ADDR = 5'd31; // Chip reset pulse

  typedef enum logic {RD_IDLE, RD_RESP} rd_state_e;

  typedef enum logic [1:0] {WR_IDLE, WR_COMMIT, WR_ACK} wr_state_e;

endpackage

`default_nettype wire

//--- design/htif_types_pkg.sv
`default_nettype none

package htif_types_pkg;

  // Widths
  localparam int BUS_W      = 32;  // Processor bus data word
  localparam int HALF_W     = 16;  // Chip host port transfer
  localparam int ID_W       = 12;
  localparam int REG_ADDR_W = 5;   // Word address of a register

  typedef logic [BUS_W-1:0]      bus_word_t;
  typedef logic [HALF_W-1:0]     host_half_t;
  typedef logic [ID_W-1:0]       axi_id_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage

`default_nettype wire
